// File: Bender.yml
package:
  name: autotest

sources:
  - files:
      - hw/autotest_pkg.sv
      - hw/sd_block_port.sv
      - hw/vector_capture.sv
      - hw/block_image.sv
      - hw/test_runner.sv
      - hw/autotest_sequencer.sv
      - hw/autotest_top.sv
  - target: test
    files:
      - bench/sd_host_model.sv
      - bench/autotest_properties.sv
      - bench/tb_autotest.sv

// File: autotest.f
hw/autotest_pkg.sv
hw/sd_block_port.sv
hw/vector_capture.sv
hw/block_image.sv
hw/test_runner.sv
hw/autotest_sequencer.sv
hw/autotest_top.sv
bench/sd_host_model.sv
bench/autotest_properties.sv
bench/tb_autotest.sv

// File: bench/autotest_properties.sv
// strobe rules of the SD host port as bound into autotest_top
// fail_count holds the number of failed checks
`timescale 1ns/1ps
`default_nettype none

module autotest_properties (
  input wire clk,
  input wire rst,
  input wire spi_r_block_i,
  input wire spi_r_byte_i,
  input wire spi_w_block_i,
  input wire spi_w_byte_i,
  input wire uut_rst_i
);

  int fail_count = 0;

  blocks_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(spi_r_block_i && spi_w_block_i))
    else begin
      fail_count++;
      $error("read and write block strobes are high together");
    end

  byte_in_block: assert property (@(posedge clk) disable iff (rst)
    (!spi_r_byte_i || spi_r_block_i) && (!spi_w_byte_i || spi_w_block_i))
    else begin
      fail_count++;
      $error("byte strobe without its block strobe");
    end

  // the UUT is held in reset for every block transfer
  uut_held: assert property (@(posedge clk) disable iff (rst)
    (spi_r_block_i || spi_w_block_i) |-> uut_rst_i)
    else begin
      fail_count++;
      $error("block strobe high while the UUT runs");
    end

endmodule

bind autotest_top autotest_properties i_properties (
  .clk          (clk),
  .rst          (rst),
  .spi_r_block_i(spi_r_block_o),
  .spi_r_byte_i (spi_r_byte_o),
  .spi_w_block_i(spi_w_block_o),
  .spi_w_byte_i (spi_w_byte_o),
  .uut_rst_i    (uut_rst_o)
);

`default_nettype wire

// File: bench/sd_host_model.sv
// behavioral SD SPI host holding blocks BASE_BLOCK up to NUM_BLOCKS-1 beyond it
// busy stays high BUSY_CYCLES clocks per command; addresses outside the image set bad_access
`timescale 1ns/1ps
`default_nettype none

module sd_host_model #(
  parameter autotest_pkg::block_addr_t BASE_BLOCK  = 32'h0010_0000,
  parameter int                        NUM_BLOCKS  = 8,
  parameter int                        BUSY_CYCLES = 3
) (
  input  wire                             clk,
  input  wire                             spi_rst_i,
  input  wire                             spi_r_block_i,
  input  wire                             spi_r_byte_i,
  input  wire                             spi_w_block_i,
  input  wire                             spi_w_byte_i,
  input  wire autotest_pkg::block_addr_t  spi_block_addr_i,
  input  wire autotest_pkg::byte_t        spi_data_in_i,
  output logic                            spi_busy_o,
  output autotest_pkg::byte_t             spi_data_out_o
);

  localparam int BLK = autotest_pkg::BLOCK_BYTES;

  autotest_pkg::byte_t       mem [0:NUM_BLOCKS*BLK-1];
  autotest_pkg::block_addr_t rd_log [0:NUM_BLOCKS-1];
  autotest_pkg::block_addr_t wr_log [0:NUM_BLOCKS-1];
  int                        rd_count;
  int                        wr_count;
  logic                      bad_access;

  function automatic int block_base(input autotest_pkg::block_addr_t addr);
    autotest_pkg::block_addr_t idx;
    idx = addr - BASE_BLOCK;
    if (idx >= NUM_BLOCKS) begin
      bad_access = 1'b1;
      return 0;
    end
    return int'(idx) * BLK;
  endfunction

  task automatic hold_busy();
    spi_busy_o <= 1'b1;
    repeat (BUSY_CYCLES) @(posedge clk);
    spi_busy_o <= 1'b0;
    // controller sees busy low at this edge
    @(posedge clk);
  endtask

  task automatic read_block();
    int base;
    base = block_base(spi_block_addr_i);
    if (rd_count < NUM_BLOCKS) rd_log[rd_count] = spi_block_addr_i;
    rd_count++;
    // block open handshake
    hold_busy();
    for (int i = 0; i < BLK; i++) begin
      while (!spi_r_byte_i) @(posedge clk);
      spi_data_out_o <= mem[base + i];
      hold_busy();
    end
  endtask

  task automatic write_block();
    int base;
    base = block_base(spi_block_addr_i);
    if (wr_count < NUM_BLOCKS) wr_log[wr_count] = spi_block_addr_i;
    for (int i = 0; i < BLK; i++) begin
      while (!spi_w_byte_i) @(posedge clk);
      mem[base + i] = spi_data_in_i;
      hold_busy();
    end
    // counted only once the whole block is stored
    wr_count++;
  endtask

  initial begin
    spi_busy_o     = 1'b0;
    spi_data_out_o = '0;
    rd_count       = 0;
    wr_count       = 0;
    bad_access     = 1'b0;
    forever begin
      @(posedge clk);
      if (spi_rst_i) begin
        hold_busy();
      end else if (spi_r_block_i) begin
        read_block();
      end else if (spi_w_block_i) begin
        write_block();
      end
    end
  end

endmodule

`default_nettype wire

// File: bench/tb_autotest.sv
// testbench of autotest_top with the SD host model and an adder UUT
// one card block per table row from INITIAL_BLOCK, then one block with a bad signature
`timescale 1ns/1ps
`default_nettype none

module tb_autotest;

  localparam int A_W            = 32;
  localparam int B_W            = 32;
  localparam int R_W            = 32;
  localparam int TIMEOUT_CYCLES = 1000;
  localparam autotest_pkg::block_addr_t INITIAL_BLOCK = 32'h0010_0000;
  localparam int NROWS          = 6;
  localparam int BLK            = autotest_pkg::BLOCK_BYTES;
  localparam int HDR            = autotest_pkg::HDR_BYTES;
  localparam int HOST_BUSY      = 3;
  localparam int HOST_BYTE      = HOST_BUSY + 4;
  // block layout
  localparam int OFF_A   = HDR;
  localparam int OFF_B   = OFF_A + A_W / 8;
  localparam int OFF_E   = OFF_B + B_W / 8;
  localparam int OFF_RES = OFF_E + R_W / 8;
  localparam int OFF_CYC = OFF_RES + R_W / 8;

  logic                      clk;
  logic                      rst;
  logic                      start_i;
  logic                      run;
  autotest_pkg::err_count_t  err_count;
  logic                      spi_rst;
  logic                      spi_r_block;
  logic                      spi_r_byte;
  logic                      spi_w_block;
  logic                      spi_w_byte;
  autotest_pkg::block_addr_t block_addr;
  autotest_pkg::byte_t       spi_data_in;
  wire                       spi_busy;
  wire autotest_pkg::byte_t  spi_data_out;
  logic                      uut_rst;
  logic [A_W-1:0]            uut_a;
  logic [B_W-1:0]            uut_b;
  logic                      uut_end;
  logic                      uut_err;
  logic [R_W-1:0]            uut_result;

  // stimulus table
  logic [A_W-1:0]      row_a [0:NROWS-1];
  logic [B_W-1:0]      row_b [0:NROWS-1];
  logic [R_W-1:0]      row_exp [0:NROWS-1];
  int                  row_lat [0:NROWS-1];
  logic                row_err [0:NROWS-1];
  logic                row_fail [0:NROWS-1];
  int                  n_rows;
  logic                table_ready;
  autotest_pkg::byte_t card [0:(NROWS+1)*BLK-1];
  integer              seed;
  int                  cur_lat;
  logic                cur_err;
  int                  uut_cnt;

  autotest_top #(
    .A_W(A_W), .B_W(B_W), .R_W(R_W),
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES),
    .INITIAL_BLOCK(INITIAL_BLOCK)
  ) i_dut (
    .clk(clk), .rst(rst), .start_i(start_i), .run_o(run), .err_count_o(err_count),
    .spi_rst_o(spi_rst), .spi_r_block_o(spi_r_block), .spi_r_byte_o(spi_r_byte),
    .spi_w_block_o(spi_w_block), .spi_w_byte_o(spi_w_byte),
    .spi_block_addr_o(block_addr), .spi_data_in_o(spi_data_in),
    .spi_busy_i(spi_busy), .spi_data_out_i(spi_data_out),
    .uut_rst_o(uut_rst), .uut_a_o(uut_a), .uut_b_o(uut_b),
    .uut_end_i(uut_end), .uut_err_i(uut_err), .uut_result_i(uut_result)
  );

  sd_host_model #(
    .BASE_BLOCK(INITIAL_BLOCK), .NUM_BLOCKS(NROWS + 1), .BUSY_CYCLES(HOST_BUSY)
  ) i_host (
    .clk(clk), .spi_rst_i(spi_rst), .spi_r_block_i(spi_r_block), .spi_r_byte_i(spi_r_byte),
    .spi_w_block_i(spi_w_block), .spi_w_byte_i(spi_w_byte),
    .spi_block_addr_i(block_addr), .spi_data_in_i(spi_data_in),
    .spi_busy_o(spi_busy), .spi_data_out_o(spi_data_out)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // adder UUT that raises end or err cur_lat cycles after its reset falls
  always @(posedge clk) begin
    if (rst || uut_rst) begin
      uut_cnt    <= 0;
      uut_end    <= 1'b0;
      uut_err    <= 1'b0;
      uut_result <= '0;
    end else begin
      uut_cnt    <= uut_cnt + 1;
      uut_result <= uut_a + uut_b;
      if (uut_cnt + 1 == cur_lat) begin
        if (cur_err) uut_err <= 1'b1;
        else uut_end <= 1'b1;
      end
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_byte(input autotest_pkg::byte_t got, exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("ERR at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_addr(input autotest_pkg::block_addr_t got, exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("ERR at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_cycles(input autotest_pkg::cycle_t got, exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("ERR at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_count(input autotest_pkg::err_count_t got, exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("ERR at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_operand(input logic [A_W-1:0] got, exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("ERR at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic add_row(input logic [A_W-1:0] a, input logic [B_W-1:0] b,
                         input logic [R_W-1:0] e, input int lat, input logic err, fail);
    row_a[n_rows]    = a;
    row_b[n_rows]    = b;
    row_exp[n_rows]  = e;
    row_lat[n_rows]  = lat;
    row_err[n_rows]  = err;
    row_fail[n_rows] = fail;
    n_rows++;
  endtask

  task automatic build_card();
    int          base;
    logic [31:0] sig;
    for (int r = 0; r <= NROWS; r++) begin
      base = r * BLK;
      for (int i = 0; i < BLK; i++) card[base + i] = autotest_pkg::byte_t'($random(seed));
      sig = (r == NROWS) ? autotest_pkg::SIGNATURE ^ 32'h1 : autotest_pkg::SIGNATURE;
      for (int i = 0; i < HDR; i++) card[base + i] = sig[8*(HDR-1-i) +: 8];
      if (r < NROWS) begin
        for (int i = 0; i < A_W / 8; i++) card[base + OFF_A + i] = row_a[r][8*i +: 8];
        for (int i = 0; i < B_W / 8; i++) card[base + OFF_B + i] = row_b[r][8*i +: 8];
        for (int i = 0; i < R_W / 8; i++) card[base + OFF_E + i] = row_exp[r][8*i +: 8];
      end
    end
    for (int i = 0; i < (NROWS + 1) * BLK; i++) i_host.mem[i] = card[i];
  endtask

  task automatic verify_write_back(input int r);
    int                   base;
    logic [R_W-1:0]       sum;
    autotest_pkg::cycle_t cyc_exp;
    autotest_pkg::cycle_t cyc_got;
    autotest_pkg::byte_t  exp;
    base    = r * BLK;
    sum     = row_a[r] + row_b[r];
    cyc_exp = (row_lat[r] > TIMEOUT_CYCLES) ? TIMEOUT_CYCLES : row_lat[r];
    for (int i = 0; i < autotest_pkg::CYCLE_BYTES; i++) begin
      cyc_got[8*i +: 8] = i_host.mem[base + OFF_CYC + i];
    end
    check_cycles(cyc_got, cyc_exp, $sformatf("cycle slot of block %0d", r));
    for (int i = 0; i < BLK; i++) begin
      if (i >= OFF_RES && i < OFF_CYC) exp = sum[8*(i-OFF_RES) +: 8];
      else if (i >= OFF_CYC && i < OFF_CYC + autotest_pkg::CYCLE_BYTES)
        exp = cyc_exp[8*(i-OFF_CYC) +: 8];
      else exp = card[base + i];
      check_byte(i_host.mem[base + i], exp, $sformatf("block %0d byte %0d", r, i));
    end
  endtask

  // a failed strobe assertion ends the run at the next falling clock edge
  always @(negedge clk) begin
    if (i_dut.i_properties.fail_count != 0) begin
      abort_run("a bound strobe assertion failed during the run");
    end
  end

  initial begin : watchdog
    int limit;
    wait (table_ready);
    // host reset plus the bad-signature block
    limit = 200 + BLK * HOST_BYTE;
    for (int r = 0; r < n_rows; r++) begin
      limit += 2 * BLK * HOST_BYTE + 100;
      limit += (row_lat[r] > TIMEOUT_CYCLES) ? TIMEOUT_CYCLES : row_lat[r];
    end
    repeat (limit) @(posedge clk);
    abort_run($sformatf("watchdog expired after %0d cycles, the controller stalled", limit));
  end

  initial begin : main
    autotest_pkg::err_count_t fails;
    rst         = 1'b1;
    start_i     = 1'b0;
    cur_lat     = 0;
    cur_err     = 1'b0;
    uut_end     = 1'b0;
    uut_err     = 1'b0;
    uut_result  = '0;
    table_ready = 1'b0;
    n_rows      = 0;
    fails       = '0;
    seed        = 32'h1f48_d14e;
    add_row(32'h0000_0003, 32'h0000_0004, 32'h0000_0007, 5, 1'b0, 1'b0);
    add_row(32'h1234_5678, 32'h0101_0101, 32'h1335_5779, 1, 1'b0, 1'b0);
    add_row(32'hffff_fff0, 32'h0000_0020, 32'h0000_0010, 12, 1'b0, 1'b0);
    // wrong expected value, UUT error, timeout
    add_row(32'h0000_0100, 32'h0000_0200, 32'h0000_0301, 7, 1'b0, 1'b1);
    add_row(32'h0000_0005, 32'h0000_0006, 32'h0000_000b, 9, 1'b1, 1'b1);
    add_row(32'hdead_0000, 32'h0000_beef, 32'hdead_beef, 1200, 1'b0, 1'b1);
    build_card();
    table_ready = 1'b1;

    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (spi_rst || spi_r_block || spi_r_byte || spi_w_block || spi_w_byte || !uut_rst || run)
      abort_run("controller outputs are not at their reset values after reset");
    check_count(err_count, '0, "error count after reset");
    @(posedge clk);
    start_i <= 1'b1;
    @(posedge clk);
    start_i <= 1'b0;
    @(negedge clk);
    if (!run || !spi_rst) abort_run("run_o and spi_rst_o did not rise on the clock after start");

    for (int r = 0; r < NROWS; r++) begin
      cur_lat = row_lat[r];
      cur_err = row_err[r];
      while (uut_rst) @(negedge clk);
      check_addr(block_addr, INITIAL_BLOCK + r, "block address during the run");
      check_addr(i_host.rd_log[r], INITIAL_BLOCK + r, "address of the block read");
      check_operand(uut_a, row_a[r], "uut_a_o");
      check_operand(uut_b, row_b[r], "uut_b_o");
      while (i_host.wr_count < r + 1) @(negedge clk);
      if (row_fail[r]) fails++;
      check_addr(i_host.wr_log[r], INITIAL_BLOCK + r, "address of the block written");
      check_count(err_count, fails, "error count after the block");
      verify_write_back(r);
    end

    while (run) @(negedge clk);
    check_count(err_count, fails, "error count at the stop");
    check_count(autotest_pkg::err_count_t'(i_host.rd_count), NROWS + 1, "blocks read");
    check_count(autotest_pkg::err_count_t'(i_host.wr_count), NROWS, "blocks written");
    check_addr(i_host.rd_log[NROWS], INITIAL_BLOCK + NROWS, "address of the bad block");
    if (i_host.bad_access) abort_run("the host saw a block address outside the card image");
    if (i_dut.i_properties.fail_count != 0) begin
      abort_run("a bound strobe assertion failed during the run");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: hw/autotest_pkg.sv
// types and constants shared by the SD self-test controller
// signature sits MSB first in byte 0; every field after it is little-endian
`default_nettype none

package autotest_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [31:0] block_addr_t;
  typedef logic [8:0]  offset_t;
  typedef logic [31:0] cycle_t;
  typedef logic [15:0] err_count_t;

  localparam int BLOCK_BYTES = 512;
  localparam int HDR_BYTES   = 4;
  localparam int CYCLE_BYTES = 4;

  // blocks without this header end the session
  localparam logic [8*HDR_BYTES-1:0] SIGNATURE = 32'hAABBCCDD;

endpackage

`default_nettype wire

// File: hw/autotest_sequencer.sv
// block loop of the self-test; stops at the first block with a bad signature
// go, clear and run_go are single-cycle pulses
`timescale 1ns/1ps
`default_nettype none

module autotest_sequencer #(
  parameter autotest_pkg::block_addr_t INITIAL_BLOCK = 32'h0010_0000
) (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       start_i,
  input  wire                       xfer_done_i,
  input  wire                       sig_ok_i,
  input  wire                       test_done_i,
  output logic                      reset_go_o,
  output logic                      rd_go_o,
  output logic                      wr_go_o,
  output logic                      run_go_o,
  output logic                      clear_o,
  output logic                      run_o,
  output autotest_pkg::block_addr_t block_addr_o
);

  localparam logic [2:0] S_IDLE    = 3'd0;
  localparam logic [2:0] S_RESET   = 3'd1;
  localparam logic [2:0] S_READ    = 3'd2;
  localparam logic [2:0] S_CHECK   = 3'd3;
  localparam logic [2:0] S_RUN     = 3'd4;
  localparam logic [2:0] S_WRITE   = 3'd5;
  localparam logic [2:0] S_ADVANCE = 3'd6;

  logic [2:0] state;
  logic [2:0] state_nxt;

  assign run_o = (state != S_IDLE);

  always_comb begin
    state_nxt  = state;
    reset_go_o = 1'b0;
    rd_go_o    = 1'b0;
    wr_go_o    = 1'b0;
    run_go_o   = 1'b0;
    clear_o    = 1'b0;
    case (state)
      S_IDLE: begin
        if (start_i) begin
          reset_go_o = 1'b1;
          clear_o    = 1'b1;
          state_nxt  = S_RESET;
        end
      end
      S_RESET: begin
        if (xfer_done_i) begin
          rd_go_o   = 1'b1;
          state_nxt = S_READ;
        end
      end
      S_READ: if (xfer_done_i) state_nxt = S_CHECK;
      S_CHECK: begin
        if (sig_ok_i) begin
          run_go_o  = 1'b1;
          state_nxt = S_RUN;
        end else begin
          state_nxt = S_IDLE;
        end
      end
      S_RUN: begin
        if (test_done_i) begin
          wr_go_o   = 1'b1;
          state_nxt = S_WRITE;
        end
      end
      S_WRITE: if (xfer_done_i) state_nxt = S_ADVANCE;
      S_ADVANCE: begin
        rd_go_o   = 1'b1;
        state_nxt = S_READ;
      end
      default: state_nxt = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= S_IDLE;
      block_addr_o <= INITIAL_BLOCK;
    end else begin
      state <= state_nxt;
      if (clear_o) begin
        block_addr_o <= INITIAL_BLOCK;
      end else if (state == S_WRITE && xfer_done_i) begin
        // next block address is in place before the read starts
        block_addr_o <= block_addr_o + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/autotest_top.sv
// SD-card driven self-test controller around an external SD SPI host and UUT
// operand and result widths must be multiples of 8
`timescale 1ns/1ps
`default_nettype none

module autotest_top #(
  parameter int                        A_W            = 32,
  parameter int                        B_W            = 32,
  parameter int                        R_W            = 32,
  parameter int                        TIMEOUT_CYCLES = 1000,
  parameter autotest_pkg::block_addr_t INITIAL_BLOCK  = 32'h0010_0000
) (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       start_i,
  output logic                      run_o,
  output autotest_pkg::err_count_t  err_count_o,
  output logic                      spi_rst_o,
  output logic                      spi_r_block_o,
  output logic                      spi_r_byte_o,
  output logic                      spi_w_block_o,
  output logic                      spi_w_byte_o,
  output autotest_pkg::block_addr_t spi_block_addr_o,
  output autotest_pkg::byte_t       spi_data_in_o,
  input  wire                       spi_busy_i,
  input  wire autotest_pkg::byte_t  spi_data_out_i,
  output logic                      uut_rst_o,
  output logic [A_W-1:0]            uut_a_o,
  output logic [B_W-1:0]            uut_b_o,
  input  wire                       uut_end_i,
  input  wire                       uut_err_i,
  input  wire [R_W-1:0]             uut_result_i
);

  logic                  reset_go;
  logic                  rd_go;
  logic                  wr_go;
  logic                  run_go;
  logic                  clear;
  logic                  xfer_done;
  logic                  sig_ok;
  logic                  test_done;
  logic                  rd_valid;
  autotest_pkg::offset_t rd_offset;
  autotest_pkg::byte_t   rd_byte;
  autotest_pkg::offset_t wr_offset;
  autotest_pkg::byte_t   wr_byte;
  logic [R_W-1:0]        expected;
  logic [R_W-1:0]        result;
  autotest_pkg::cycle_t  cycles;

  autotest_sequencer #(
    .INITIAL_BLOCK(INITIAL_BLOCK)
  ) i_sequencer (
    .clk         (clk),
    .rst         (rst),
    .start_i     (start_i),
    .xfer_done_i (xfer_done),
    .sig_ok_i    (sig_ok),
    .test_done_i (test_done),
    .reset_go_o  (reset_go),
    .rd_go_o     (rd_go),
    .wr_go_o     (wr_go),
    .run_go_o    (run_go),
    .clear_o     (clear),
    .run_o       (run_o),
    .block_addr_o(spi_block_addr_o)
  );

  sd_block_port i_port (
    .clk           (clk),
    .rst           (rst),
    .reset_go_i    (reset_go),
    .rd_go_i       (rd_go),
    .wr_go_i       (wr_go),
    .spi_busy_i    (spi_busy_i),
    .spi_data_out_i(spi_data_out_i),
    .wr_byte_i     (wr_byte),
    .spi_rst_o     (spi_rst_o),
    .spi_r_block_o (spi_r_block_o),
    .spi_r_byte_o  (spi_r_byte_o),
    .spi_w_block_o (spi_w_block_o),
    .spi_w_byte_o  (spi_w_byte_o),
    .spi_data_in_o (spi_data_in_o),
    .rd_valid_o    (rd_valid),
    .rd_offset_o   (rd_offset),
    .rd_byte_o     (rd_byte),
    .wr_offset_o   (wr_offset),
    .xfer_done_o   (xfer_done)
  );

  vector_capture #(
    .A_W(A_W),
    .B_W(B_W),
    .R_W(R_W)
  ) i_capture (
    .clk        (clk),
    .rd_valid_i (rd_valid),
    .rd_offset_i(rd_offset),
    .rd_byte_i  (rd_byte),
    .sig_ok_o   (sig_ok),
    .uut_a_o    (uut_a_o),
    .uut_b_o    (uut_b_o),
    .expected_o (expected)
  );

  block_image #(
    .A_W(A_W),
    .B_W(B_W),
    .R_W(R_W)
  ) i_image (
    .clk        (clk),
    .rd_valid_i (rd_valid),
    .rd_offset_i(rd_offset),
    .rd_byte_i  (rd_byte),
    .wr_offset_i(wr_offset),
    .result_i   (result),
    .cycles_i   (cycles),
    .wr_byte_o  (wr_byte)
  );

  test_runner #(
    .R_W           (R_W),
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
  ) i_runner (
    .clk         (clk),
    .rst         (rst),
    .run_go_i    (run_go),
    .clear_i     (clear),
    .expected_i  (expected),
    .uut_end_i   (uut_end_i),
    .uut_err_i   (uut_err_i),
    .uut_result_i(uut_result_i),
    .uut_rst_o   (uut_rst_o),
    .test_done_o (test_done),
    .result_o    (result),
    .cycles_o    (cycles),
    .err_count_o (err_count_o)
  );

endmodule

`default_nettype wire

// File: hw/block_image.sv
// copy of the block as read; the write-back swaps in result and cycle bytes
// wr_byte_o lags wr_offset_i by one clock
`timescale 1ns/1ps
`default_nettype none

module block_image #(
  parameter int A_W = 32,
  parameter int B_W = 32,
  parameter int R_W = 32
) (
  input  wire                        clk,
  input  wire                        rd_valid_i,
  input  wire autotest_pkg::offset_t rd_offset_i,
  input  wire autotest_pkg::byte_t   rd_byte_i,
  input  wire autotest_pkg::offset_t wr_offset_i,
  input  wire [R_W-1:0]              result_i,
  input  wire autotest_pkg::cycle_t  cycles_i,
  output autotest_pkg::byte_t        wr_byte_o
);

  localparam int OFF_RES = autotest_pkg::HDR_BYTES + (A_W + B_W + R_W) / 8;
  localparam int OFF_CYC = OFF_RES + R_W / 8;

  autotest_pkg::byte_t   mem [autotest_pkg::BLOCK_BYTES];
  autotest_pkg::offset_t res_idx;
  autotest_pkg::offset_t cyc_idx;
  logic                  in_res;
  logic                  in_cyc;

  assign res_idx = wr_offset_i - autotest_pkg::offset_t'(OFF_RES);
  assign cyc_idx = wr_offset_i - autotest_pkg::offset_t'(OFF_CYC);
  assign in_res  = (wr_offset_i >= OFF_RES) && (wr_offset_i < OFF_CYC);
  assign in_cyc  = (wr_offset_i >= OFF_CYC) &&
                   (wr_offset_i < OFF_CYC + autotest_pkg::CYCLE_BYTES);

  always_ff @(posedge clk) begin
    if (rd_valid_i) mem[rd_offset_i] <= rd_byte_i;
  end

  always_ff @(posedge clk) begin
    if (in_res) begin
      wr_byte_o <= autotest_pkg::byte_t'(result_i >> (8 * res_idx));
    end else if (in_cyc) begin
      wr_byte_o <= autotest_pkg::byte_t'(cycles_i >> (8 * cyc_idx));
    end else begin
      wr_byte_o <= mem[wr_offset_i];
    end
  end

endmodule

`default_nettype wire

// File: hw/sd_block_port.sv
// drives the SD SPI host strobes by its busy level only, one transfer at a time
// a go request is taken only while the port is idle
`timescale 1ns/1ps
`default_nettype none

module sd_block_port (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      reset_go_i,
  input  wire                      rd_go_i,
  input  wire                      wr_go_i,
  input  wire                      spi_busy_i,
  input  wire autotest_pkg::byte_t spi_data_out_i,
  input  wire autotest_pkg::byte_t wr_byte_i,
  output logic                     spi_rst_o,
  output logic                     spi_r_block_o,
  output logic                     spi_r_byte_o,
  output logic                     spi_w_block_o,
  output logic                     spi_w_byte_o,
  output autotest_pkg::byte_t      spi_data_in_o,
  output logic                     rd_valid_o,
  output autotest_pkg::offset_t    rd_offset_o,
  output autotest_pkg::byte_t      rd_byte_o,
  output autotest_pkg::offset_t    wr_offset_o,
  output logic                     xfer_done_o
);

  localparam logic [3:0] S_IDLE     = 4'd0;
  localparam logic [3:0] S_RST_HOLD = 4'd1;
  localparam logic [3:0] S_RST_WAIT = 4'd2;
  localparam logic [3:0] S_RD_OPEN  = 4'd3;
  localparam logic [3:0] S_RD_SYNC  = 4'd4;
  localparam logic [3:0] S_RD_BYTE  = 4'd5;
  localparam logic [3:0] S_RD_WAIT  = 4'd6;
  localparam logic [3:0] S_WR_PREP  = 4'd7;
  localparam logic [3:0] S_WR_BYTE  = 4'd8;
  localparam logic [3:0] S_WR_WAIT  = 4'd9;

  localparam autotest_pkg::offset_t LAST_OFFSET =
    autotest_pkg::offset_t'(autotest_pkg::BLOCK_BYTES - 1);

  logic [3:0]            state;
  autotest_pkg::offset_t offset;
  logic                  last_byte;

  assign last_byte     = (offset == LAST_OFFSET);
  assign wr_offset_o   = offset;
  // block_image holds this byte steady while the offset stands
  assign spi_data_in_o = wr_byte_i;

  always_comb begin
    spi_rst_o     = (state == S_RST_HOLD);
    spi_r_block_o = state inside {S_RD_OPEN, S_RD_SYNC, S_RD_BYTE, S_RD_WAIT};
    spi_r_byte_o  = (state == S_RD_BYTE);
    spi_w_block_o = state inside {S_WR_PREP, S_WR_BYTE, S_WR_WAIT};
    spi_w_byte_o  = (state == S_WR_BYTE);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= S_IDLE;
      offset      <= '0;
      rd_valid_o  <= 1'b0;
      xfer_done_o <= 1'b0;
    end else begin
      rd_valid_o  <= 1'b0;
      xfer_done_o <= 1'b0;
      case (state)
        S_IDLE: begin
          offset <= '0;
          if (reset_go_i) begin
            state <= S_RST_HOLD;
          end else if (rd_go_i) begin
            state <= S_RD_OPEN;
          end else if (wr_go_i) begin
            state <= S_WR_PREP;
          end
        end
        S_RST_HOLD: if (spi_busy_i) state <= S_RST_WAIT;
        S_RST_WAIT: begin
          if (!spi_busy_i) begin
            state       <= S_IDLE;
            xfer_done_o <= 1'b1;
          end
        end
        S_RD_OPEN: if (spi_busy_i) state <= S_RD_SYNC;
        S_RD_SYNC: if (!spi_busy_i) state <= S_RD_BYTE;
        S_RD_BYTE: if (spi_busy_i) state <= S_RD_WAIT;
        S_RD_WAIT: begin
          // byte is valid on the falling edge of busy
          if (!spi_busy_i) begin
            rd_valid_o <= 1'b1;
            if (last_byte) begin
              state       <= S_IDLE;
              xfer_done_o <= 1'b1;
            end else begin
              offset <= offset + 1'b1;
              state  <= S_RD_BYTE;
            end
          end
        end
        // one cycle for the image read of the new offset
        S_WR_PREP: state <= S_WR_BYTE;
        S_WR_BYTE: if (spi_busy_i) state <= S_WR_WAIT;
        S_WR_WAIT: begin
          if (!spi_busy_i) begin
            if (last_byte) begin
              state       <= S_IDLE;
              xfer_done_o <= 1'b1;
            end else begin
              offset <= offset + 1'b1;
              state  <= S_WR_PREP;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_RD_WAIT && !spi_busy_i) begin
      rd_offset_o <= offset;
      rd_byte_o   <= spi_data_out_i;
    end
  end

endmodule

`default_nettype wire

// File: hw/test_runner.sv
// runs the UUT once per run_go and counts cycles until end, error or timeout
// a timeout or uut error always counts as a failure
`timescale 1ns/1ps
`default_nettype none

module test_runner #(
  parameter int R_W            = 32,
  parameter int TIMEOUT_CYCLES = 1000
) (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      run_go_i,
  input  wire                      clear_i,
  input  wire [R_W-1:0]            expected_i,
  input  wire                      uut_end_i,
  input  wire                      uut_err_i,
  input  wire [R_W-1:0]            uut_result_i,
  output logic                     uut_rst_o,
  output logic                     test_done_o,
  output logic [R_W-1:0]           result_o,
  output autotest_pkg::cycle_t     cycles_o,
  output autotest_pkg::err_count_t err_count_o
);

  localparam autotest_pkg::cycle_t LAST_COUNT = autotest_pkg::cycle_t'(TIMEOUT_CYCLES - 1);

  logic stopped;
  logic finish;
  logic failed;

  assign stopped = uut_end_i || uut_err_i;
  assign finish  = !uut_rst_o && (stopped || cycles_o == LAST_COUNT);
  // no end flag at finish means the timer ran out
  assign failed  = uut_err_i || !uut_end_i || (uut_result_i != expected_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      uut_rst_o   <= 1'b1;
      test_done_o <= 1'b0;
      err_count_o <= '0;
    end else begin
      test_done_o <= 1'b0;
      if (clear_i) err_count_o <= '0;
      if (run_go_i) begin
        uut_rst_o <= 1'b0;
      end else if (finish) begin
        uut_rst_o   <= 1'b1;
        test_done_o <= 1'b1;
        if (failed) err_count_o <= err_count_o + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (run_go_i) begin
      cycles_o <= '0;
    end else if (!uut_rst_o && !stopped) begin
      cycles_o <= cycles_o + 1'b1;
    end
    if (finish) result_o <= uut_result_i;
  end

endmodule

`default_nettype wire

// File: hw/vector_capture.sv
// picks the header, operands and expected result out of the read stream
// field widths must be multiples of 8
`timescale 1ns/1ps
`default_nettype none

module vector_capture #(
  parameter int A_W = 32,
  parameter int B_W = 32,
  parameter int R_W = 32
) (
  input  wire                        clk,
  input  wire                        rd_valid_i,
  input  wire autotest_pkg::offset_t rd_offset_i,
  input  wire autotest_pkg::byte_t   rd_byte_i,
  output logic                       sig_ok_o,
  output logic [A_W-1:0]             uut_a_o,
  output logic [B_W-1:0]             uut_b_o,
  output logic [R_W-1:0]             expected_o
);

  localparam int HDR   = autotest_pkg::HDR_BYTES;
  localparam int OFF_A = HDR;
  localparam int OFF_B = OFF_A + A_W / 8;
  localparam int OFF_E = OFF_B + B_W / 8;

  logic [8*HDR-1:0] sig_q;

  assign sig_ok_o = (sig_q == autotest_pkg::SIGNATURE);

  always_ff @(posedge clk) begin
    if (rd_valid_i) begin
      // header is big-endian
      for (int i = 0; i < HDR; i++) begin
        if (rd_offset_i == autotest_pkg::offset_t'(i)) sig_q[8*(HDR-1-i) +: 8] <= rd_byte_i;
      end
      for (int i = 0; i < A_W / 8; i++) begin
        if (rd_offset_i == autotest_pkg::offset_t'(OFF_A + i)) uut_a_o[8*i +: 8] <= rd_byte_i;
      end
      for (int i = 0; i < B_W / 8; i++) begin
        if (rd_offset_i == autotest_pkg::offset_t'(OFF_B + i)) uut_b_o[8*i +: 8] <= rd_byte_i;
      end
      for (int i = 0; i < R_W / 8; i++) begin
        if (rd_offset_i == autotest_pkg::offset_t'(OFF_E + i)) expected_o[8*i +: 8] <= rd_byte_i;
      end
    end
  end

endmodule

`default_nettype wire
